//--- Makefile
# Verilator build and run of the execute stage testbench

VERILATOR ?= verilator
TOP       ?= ex_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- hw/ex_alu.sv
/*
  Single-cycle integer ALU for the RV32I register-register operations.
  Only the low five bits of operand b are used as shift amount.
*/
`timescale 1ns/1ps
`default_nettype none

module ex_alu import ex_pkg::*; (
  input  alu_op_e              operator_i,
  input  wire logic [XLEN-1:0] operand_a_i,
  input  wire logic [XLEN-1:0] operand_b_i,
  output logic [XLEN-1:0]      result_o
);

  logic            sub_en, cmp_signed;
  logic [XLEN:0]   adder_a, adder_b, adder_ext;
  logic            less_than;
  logic            shift_left, shift_arith;
  logic [4:0]      shamt;
  logic [XLEN-1:0] shift_in, shift_right;
  logic [XLEN:0]   shift_ext;

  function automatic logic [XLEN-1:0] bit_reverse(input logic [XLEN-1:0] val);
    logic [XLEN-1:0] rev;
    for (int i = 0; i < XLEN; i++) begin
      rev[i] = val[XLEN-1-i];
    end
    return rev;
  endfunction

  //////////////////////////////////////////////////
  // Adder and comparison
  //////////////////////////////////////////////////

  assign sub_en     = operator_i inside {ALU_SUB, ALU_SLT, ALU_SLTU};
  assign cmp_signed = (operator_i == ALU_SLT);

  // One extra bit keeps the sign of a - b for both signed and unsigned compares
  assign adder_a   = {cmp_signed & operand_a_i[XLEN-1], operand_a_i};
  assign adder_b   = {cmp_signed & operand_b_i[XLEN-1], operand_b_i};
  assign adder_ext = adder_a + (sub_en ? ~adder_b : adder_b) + {{XLEN{1'b0}}, sub_en};
  assign less_than = adder_ext[XLEN];

  //////////////////////////////////////////////////
  // Shifter
  //////////////////////////////////////////////////

  // Left shifts reverse the operand and reuse the right shifter
  assign shift_left  = (operator_i == ALU_SLL);
  assign shift_arith = (operator_i == ALU_SRA);
  assign shamt       = operand_b_i[4:0];
  assign shift_in    = shift_left ? bit_reverse(operand_a_i) : operand_a_i;
  assign shift_ext   = $signed({shift_arith & shift_in[XLEN-1], shift_in}) >>> shamt;
  assign shift_right = shift_ext[XLEN-1:0];

  always_comb begin
    case (operator_i)
      ALU_ADD,
      ALU_SUB:  result_o = adder_ext[XLEN-1:0];
      ALU_SLL:  result_o = bit_reverse(shift_right);
      ALU_SRL,
      ALU_SRA:  result_o = shift_right;
      ALU_SLT,
      ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, less_than};
      ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
      ALU_OR:   result_o = operand_a_i | operand_b_i;
      ALU_AND:  result_o = operand_a_i & operand_b_i;
      default:  result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- hw/ex_block.sv
/*
  Execute stage. ALU and illegal ops complete in the op_valid cycle; a
  multiply or divide completes when the iterative unit reports valid.
  Operands from the decoder must stay stable until completion.
*/
`timescale 1ns/1ps
`default_nettype none

module ex_block import ex_pkg::*; #(
  parameter bit RV32M = 1'b1
) (
  input  wire logic            clk_i,
  input  wire logic            rst_n_i,
  input  wire logic            op_valid_i,
  input  wire logic            alu_sel_i,
  input  alu_op_e              alu_op_i,
  input  wire logic            md_sel_i,
  input  md_op_e               md_op_i,
  input  wire logic            illegal_i,
  input  wire logic [XLEN-1:0] op_a_i,
  input  wire logic [XLEN-1:0] op_b_i,
  output logic                 ex_valid_o,
  output logic [XLEN-1:0]      ex_result_o
);

  logic [XLEN-1:0] alu_result, md_result;
  logic            md_start, md_valid, md_active_q;

  ex_alu u_alu (
    .operator_i  (alu_op_i),
    .operand_a_i (op_a_i),
    .operand_b_i (op_b_i),
    .result_o    (alu_result)
  );

  assign md_start = op_valid_i & md_sel_i;

  if (RV32M) begin : gen_multdiv
    ex_multdiv_slow u_multdiv (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .start_i    (md_start),
      .operator_i (md_op_i),
      .op_a_i     (op_a_i),
      .op_b_i     (op_b_i),
      .valid_o    (md_valid),
      .result_o   (md_result)
    );
  end else begin : gen_no_multdiv
    assign md_valid  = 1'b0;
    assign md_result = '0;
  end

  // Multiply/divide in flight
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      md_active_q <= 1'b0;
    end else if (md_start) begin
      md_active_q <= 1'b1;
    end else if (md_valid) begin
      md_active_q <= 1'b0;
    end
  end

  assign ex_valid_o  = (op_valid_i & (alu_sel_i | illegal_i)) | (md_active_q & md_valid);
  // Illegal words select neither unit and return zero
  assign ex_result_o = md_active_q ? md_result : (alu_sel_i ? alu_result : '0);

endmodule

`default_nettype wire

//--- hw/ex_decoder.sv
/*
  Decode stage. A strobe is accepted only while not busy; strobes given while
  busy are dropped. Busy holds until the execute stage reports completion.
  With RV32M at 0 the M-extension words decode as illegal.
*/
`timescale 1ns/1ps
`default_nettype none

module ex_decoder import ex_pkg::*; #(
  parameter bit RV32M    = 1'b1,
  parameter int TagWidth = 4
) (
  input  wire logic                clk_i,
  input  wire logic                rst_n_i,
  input  wire logic                instr_valid_i,
  input  wire logic [31:0]         instr_i,
  input  wire logic [XLEN-1:0]     operand_a_i,
  input  wire logic [XLEN-1:0]     operand_b_i,
  input  wire logic [TagWidth-1:0] tag_i,
  input  wire logic                ex_valid_i,
  output logic                     op_valid_o,
  output logic                     alu_sel_o,
  output alu_op_e                  alu_op_o,
  output logic                     md_sel_o,
  output md_op_e                   md_op_o,
  output logic                     illegal_o,
  output logic [XLEN-1:0]          op_a_o,
  output logic [XLEN-1:0]          op_b_o,
  output logic [TagWidth-1:0]      tag_o,
  output logic                     busy_o
);

  logic [6:0] opcode, funct7;
  logic [2:0] funct3;
  logic       accept;
  logic       alu_sel_d, md_sel_d;
  alu_op_e    alu_op_d;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  assign accept = instr_valid_i & ~busy_o;

  always_comb begin
    alu_sel_d = 1'b0;
    md_sel_d  = 1'b0;
    alu_op_d  = ALU_ADD;
    if (opcode == OPC_OP) begin
      if (funct7 == F7_BASE) begin
        alu_sel_d = 1'b1;
        case (funct3)
          F3_ADD_SUB: alu_op_d = ALU_ADD;
          F3_SLL:     alu_op_d = ALU_SLL;
          F3_SLT:     alu_op_d = ALU_SLT;
          F3_SLTU:    alu_op_d = ALU_SLTU;
          F3_XOR:     alu_op_d = ALU_XOR;
          F3_SRL_SRA: alu_op_d = ALU_SRL;
          F3_OR:      alu_op_d = ALU_OR;
          F3_AND:     alu_op_d = ALU_AND;
          default:    alu_sel_d = 1'b0;
        endcase
      end else if (funct7 == F7_ALT) begin
        // Only SUB and SRA use the alternate funct7
        if (funct3 == F3_ADD_SUB) begin
          alu_sel_d = 1'b1;
          alu_op_d  = ALU_SUB;
        end else if (funct3 == F3_SRL_SRA) begin
          alu_sel_d = 1'b1;
          alu_op_d  = ALU_SRA;
        end
      end else if (funct7 == F7_MULDIV) begin
        md_sel_d = RV32M;
      end
    end
  end

  // Control flags
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      op_valid_o <= 1'b0;
      busy_o     <= 1'b0;
      alu_sel_o  <= 1'b0;
      md_sel_o   <= 1'b0;
      illegal_o  <= 1'b0;
    end else begin
      op_valid_o <= accept;
      if (accept) begin
        busy_o    <= 1'b1;
        alu_sel_o <= alu_sel_d;
        md_sel_o  <= md_sel_d;
        illegal_o <= ~alu_sel_d & ~md_sel_d;
      end else if (ex_valid_i) begin
        busy_o <= 1'b0;
      end
    end
  end

  // Operation payload, held until the next accepted word
  always_ff @(posedge clk_i) begin
    if (accept) begin
      alu_op_o <= alu_op_d;
      md_op_o  <= md_op_e'(funct3);
      op_a_o   <= operand_a_i;
      op_b_o   <= operand_b_i;
      tag_o    <= tag_i;
    end
  end

endmodule

`default_nettype wire

//--- hw/ex_multdiv_slow.sv
/*
  Iterative multiplier and divider, one result bit per cycle on magnitudes.
  Latency is fixed at 34 cycles from start_i to valid_o. start_i is only
  looked at while idle; operands are captured with it.
*/
`timescale 1ns/1ps
`default_nettype none

module ex_multdiv_slow import ex_pkg::*; (
  input  wire logic            clk_i,
  input  wire logic            rst_n_i,
  input  wire logic            start_i,
  input  md_op_e               operator_i,
  input  wire logic [XLEN-1:0] op_a_i,
  input  wire logic [XLEN-1:0] op_b_i,
  output logic                 valid_o,
  output logic [XLEN-1:0]      result_o
);

  typedef enum logic [1:0] {IDLE, INIT, ITERATE, FINISH} md_state_e;

  md_state_e         state_q;
  logic [4:0]        cnt_q;
  md_op_e            op_q;
  logic [XLEN-1:0]   a_q, b_q;
  logic [XLEN-1:0]   acc_q, mpl_q, mcand_q;
  logic              is_mul, neg_a, neg_b;
  logic [XLEN-1:0]   abs_a, abs_b;
  logic [XLEN:0]     mul_sum, rem_shift;
  logic [XLEN+1:0]   div_diff;
  logic              q_bit;
  logic [2*XLEN-1:0] prod, prod_fix;
  logic              div_zero;
  logic [XLEN-1:0]   quot_fix, rem_fix;

  // Operand signs, from the captured operands
  assign is_mul = ~op_q[2];
  assign neg_a  = a_q[XLEN-1] & (op_q inside {MD_MULH, MD_MULHSU, MD_DIV, MD_REM});
  assign neg_b  = b_q[XLEN-1] & (op_q inside {MD_MULH, MD_DIV, MD_REM});
  assign abs_a  = neg_a ? -a_q : a_q;
  assign abs_b  = neg_b ? -b_q : b_q;

  // Shift-add step, low product bits shift into mpl_q
  assign mul_sum = {1'b0, acc_q} + (mpl_q[0] ? {1'b0, mcand_q} : '0);

  // Restoring division step, quotient bits shift into mpl_q
  assign rem_shift = {acc_q, mpl_q[XLEN-1]};
  assign div_diff  = {1'b0, rem_shift} - {2'b00, mcand_q};
  assign q_bit     = ~div_diff[XLEN+1];

  //////////////////////////////////////////////////
  // Sequencing
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        IDLE:    if (start_i) state_q <= INIT;
        INIT: begin
          cnt_q   <= 5'd31;
          state_q <= ITERATE;
        end
        ITERATE: begin
          cnt_q <= cnt_q - 5'd1;
          if (cnt_q == 5'd0) state_q <= FINISH;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Datapath registers
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && start_i) begin
      op_q <= operator_i;
      a_q  <= op_a_i;
      b_q  <= op_b_i;
    end else if (state_q == INIT) begin
      acc_q   <= '0;
      mpl_q   <= abs_a;
      mcand_q <= abs_b;
    end else if (state_q == ITERATE) begin
      if (is_mul) begin
        acc_q <= mul_sum[XLEN:1];
        mpl_q <= {mul_sum[0], mpl_q[XLEN-1:1]};
      end else begin
        acc_q <= q_bit ? div_diff[XLEN-1:0] : rem_shift[XLEN-1:0];
        mpl_q <= {mpl_q[XLEN-2:0], q_bit};
      end
    end
  end

  //////////////////////////////////////////////////
  // Sign fix-up
  //////////////////////////////////////////////////

  assign prod     = {acc_q, mpl_q};
  assign prod_fix = (neg_a ^ neg_b) ? -prod : prod;

  // A zero divisor leaves the all-ones quotient unsigned
  assign div_zero = (b_q == '0);
  assign quot_fix = ((neg_a ^ neg_b) & ~div_zero) ? -mpl_q : mpl_q;
  assign rem_fix  = neg_a ? -acc_q : acc_q;

  always_comb begin
    case (op_q)
      MD_MUL:                       result_o = prod_fix[XLEN-1:0];
      MD_MULH, MD_MULHSU, MD_MULHU: result_o = prod_fix[2*XLEN-1:XLEN];
      MD_DIV, MD_DIVU:              result_o = quot_fix;
      default:                      result_o = rem_fix;
    endcase
  end

  assign valid_o = (state_q == FINISH);

endmodule

`default_nettype wire

//--- hw/ex_pkg.sv
/*
  Shared definitions for the RV32 execute stage.
  Only R-type words with opcode OP are decoded. The md_op_e values follow the
  funct3 order of the M extension so that funct3 maps onto them directly.
*/
`default_nettype none

package ex_pkg;

  // Data width of operands and results
  localparam int XLEN = 32;

  //////////////////////////////////////////////////
  // Instruction fields
  //////////////////////////////////////////////////

  localparam logic [6:0] OPC_OP = 7'b0110011;

  localparam logic [6:0] F7_BASE   = 7'b0000000;
  localparam logic [6:0] F7_ALT    = 7'b0100000;
  localparam logic [6:0] F7_MULDIV = 7'b0000001;

  // funct3 codes of the base integer ops
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  //////////////////////////////////////////////////
  // Operation encodings
  //////////////////////////////////////////////////

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_e;

  // Bit 2 set means a divide or remainder
  typedef enum logic [2:0] {
    MD_MUL    = 3'b000,
    MD_MULH   = 3'b001,
    MD_MULHSU = 3'b010,
    MD_MULHU  = 3'b011,
    MD_DIV    = 3'b100,
    MD_DIVU   = 3'b101,
    MD_REM    = 3'b110,
    MD_REMU   = 3'b111
  } md_op_e;

endpackage

`default_nettype wire

//--- hw/ex_result.sv
/*
  Result stage. result_valid_o is a one-cycle strobe; the data outputs hold
  their last captured values until the next completion.
*/
`timescale 1ns/1ps
`default_nettype none

module ex_result import ex_pkg::*; #(
  parameter int TagWidth = 4
) (
  input  wire logic                clk_i,
  input  wire logic                rst_n_i,
  input  wire logic                ex_valid_i,
  input  wire logic [XLEN-1:0]     ex_result_i,
  input  wire logic [TagWidth-1:0] tag_i,
  input  wire logic                illegal_i,
  output logic                     result_valid_o,
  output logic [XLEN-1:0]          result_o,
  output logic [TagWidth-1:0]      result_tag_o,
  output logic                     illegal_o
);

  // Strobe and flag
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      result_valid_o <= 1'b0;
      illegal_o      <= 1'b0;
    end else begin
      result_valid_o <= ex_valid_i;
      if (ex_valid_i) illegal_o <= illegal_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ex_valid_i) begin
      result_o     <= ex_result_i;
      result_tag_o <= tag_i;
    end
  end

endmodule

`default_nettype wire

//--- hw/ex_top.sv
/*
  RV32 execute subsystem. One R-type word in flight at a time, no
  back-pressure: the issuer waits while busy_o is high.
*/
`timescale 1ns/1ps
`default_nettype none

module ex_top import ex_pkg::*; #(
  parameter bit RV32M    = 1'b1,
  parameter int TagWidth = 4
) (
  input  wire logic                clk_i,
  input  wire logic                rst_n_i,
  input  wire logic                instr_valid_i,
  input  wire logic [31:0]         instr_i,
  input  wire logic [XLEN-1:0]     operand_a_i,
  input  wire logic [XLEN-1:0]     operand_b_i,
  input  wire logic [TagWidth-1:0] tag_i,
  output logic                     result_valid_o,
  output logic [XLEN-1:0]          result_o,
  output logic [TagWidth-1:0]      result_tag_o,
  output logic                     illegal_o,
  output logic                     busy_o
);

  logic                op_valid, alu_sel, md_sel, illegal;
  alu_op_e             alu_op;
  md_op_e              md_op;
  logic [XLEN-1:0]     op_a, op_b, ex_result;
  logic [TagWidth-1:0] tag;
  logic                ex_valid;

  ex_decoder #(.RV32M(RV32M), .TagWidth(TagWidth)) u_decoder (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .instr_valid_i(instr_valid_i), .instr_i(instr_i),
    .operand_a_i(operand_a_i), .operand_b_i(operand_b_i), .tag_i(tag_i),
    .ex_valid_i(ex_valid),
    .op_valid_o(op_valid), .alu_sel_o(alu_sel), .alu_op_o(alu_op),
    .md_sel_o(md_sel), .md_op_o(md_op), .illegal_o(illegal),
    .op_a_o(op_a), .op_b_o(op_b), .tag_o(tag), .busy_o(busy_o)
  );

  ex_block #(.RV32M(RV32M)) u_ex_block (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .op_valid_i(op_valid),
    .alu_sel_i(alu_sel), .alu_op_i(alu_op), .md_sel_i(md_sel), .md_op_i(md_op),
    .illegal_i(illegal), .op_a_i(op_a), .op_b_i(op_b),
    .ex_valid_o(ex_valid), .ex_result_o(ex_result)
  );

  ex_result #(.TagWidth(TagWidth)) u_result (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .ex_valid_i(ex_valid),
    .ex_result_i(ex_result), .tag_i(tag), .illegal_i(illegal),
    .result_valid_o(result_valid_o), .result_o(result_o),
    .result_tag_o(result_tag_o), .illegal_o(illegal_o)
  );

endmodule

`default_nettype wire

//--- tb.f
hw/ex_pkg.sv
hw/ex_decoder.sv
hw/ex_alu.sv
hw/ex_multdiv_slow.sv
hw/ex_block.sv
hw/ex_result.sv
hw/ex_top.sv
verif/ex_tb.sv

//--- verif/ex_tb.sv
/*
  Directed testbench for the RV32 execute stage, built with RV32M at 1.
  Expected values come from a reference model of the RV32I/M rules.
  The issuer waits for each result before the next strobe.
*/
`timescale 1ns/1ps
`default_nettype none

module ex_tb;

  localparam int NUM_OPS        = 120;
  localparam int TIMEOUT_CYCLES = NUM_OPS * 40 + 200;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  logic        clk, rst_n_i, instr_valid_i;
  logic [31:0] instr_i, operand_a_i, operand_b_i, result_o;
  logic [3:0]  tag_i, result_tag_o, next_tag;
  logic        result_valid_o, illegal_o, busy_o;
  logic [31:0] lfsr_state = 32'h4ffd;
  int          n_checks = 0;
  int          n_errors = 0;
  int          cycle_count = 0;

  ex_top #(.RV32M(1'b1), .TagWidth(4)) dut0 (
    .clk_i(clk), .rst_n_i(rst_n_i), .instr_valid_i(instr_valid_i), .instr_i(instr_i),
    .operand_a_i(operand_a_i), .operand_b_i(operand_b_i), .tag_i(tag_i),
    .result_valid_o(result_valid_o), .result_o(result_o), .result_tag_o(result_tag_o),
    .illegal_o(illegal_o), .busy_o(busy_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: no end of test after %0d cycles", TIMEOUT_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Stimulus and reference helpers
  //////////////////////////////////////////////////

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] random_bits(input int nbits);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < nbits; i++) begin
      val        = {val[30:0], lfsr_state[0]};
      lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? LFSR_TAPS : 32'h0);
    end
    return val;
  endfunction

  // rd = x3, rs1 = x1, rs2 = x2
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3);
    return {f7, 5'd2, 5'd1, f3, 5'd3, 7'b0110011};
  endfunction

  // Same fields with another opcode
  function automatic logic [31:0] with_opcode(input logic [31:0] word, input logic [6:0] opc);
    return {word[31:7], opc};
  endfunction

  function automatic logic [31:0] alu_word(input int idx);
    case (idx)
      0:       return r_type(7'h00, 3'd0);
      1:       return r_type(7'h20, 3'd0);
      2:       return r_type(7'h00, 3'd1);
      3:       return r_type(7'h00, 3'd2);
      4:       return r_type(7'h00, 3'd3);
      5:       return r_type(7'h00, 3'd4);
      6:       return r_type(7'h00, 3'd5);
      7:       return r_type(7'h20, 3'd5);
      8:       return r_type(7'h00, 3'd6);
      default: return r_type(7'h00, 3'd7);
    endcase
  endfunction

  // Returns {illegal, result}
  function automatic logic [32:0] reference_model(input logic [31:0] instr, a, b);
    logic [6:0]  opc, f7;
    logic [2:0]  f3;
    logic [63:0] sa, sb, ua, ub, prod;
    logic [31:0] res;
    logic        bad, ovf;
    opc = instr[6:0];
    f3  = instr[14:12];
    f7  = instr[31:25];
    sa  = {{32{a[31]}}, a};
    sb  = {{32{b[31]}}, b};
    ua  = {32'h0, a};
    ub  = {32'h0, b};
    ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    res = '0;
    bad = 1'b0;
    if (opc != 7'b0110011) begin
      bad = 1'b1;
    end else if (f7 == 7'h00) begin
      case (f3)
        3'd0: res = a + b;
        3'd1: res = a << b[4:0];
        3'd2: res = {31'h0, $signed(a) < $signed(b)};
        3'd3: res = {31'h0, a < b};
        3'd4: res = a ^ b;
        3'd5: res = a >> b[4:0];
        3'd6: res = a | b;
        3'd7: res = a & b;
      endcase
    end else if (f7 == 7'h20 && f3 == 3'd0) begin
      res = a - b;
    end else if (f7 == 7'h20 && f3 == 3'd5) begin
      res = $signed(a) >>> b[4:0];
    end else if (f7 == 7'h01) begin
      case (f3)
        3'd0: begin
          prod = ua * ub;
          res  = prod[31:0];
        end
        3'd1: begin
          prod = sa * sb;
          res  = prod[63:32];
        end
        3'd2: begin
          prod = sa * ub;
          res  = prod[63:32];
        end
        3'd3: begin
          prod = ua * ub;
          res  = prod[63:32];
        end
        3'd4: begin
          if (b == 0) res = 32'hffff_ffff;
          else if (ovf) res = a;
          else res = $signed(a) / $signed(b);
        end
        3'd5: res = (b == 0) ? 32'hffff_ffff : a / b;
        3'd6: begin
          if (b == 0) res = a;
          else if (ovf) res = 32'h0;
          else res = $signed(a) % $signed(b);
        end
        3'd7: res = (b == 0) ? a : a % b;
      endcase
    end else begin
      bad = 1'b1;
    end
    return {bad, res};
  endfunction

  task automatic check_word(input string name, input string what, input logic [31:0] exp,
                            input logic [31:0] got);
    n_checks++;
    assert (got === exp) else begin
      $display("** Error [%s] %s expected %h actual %h", name, what, exp, got);
      n_errors++;
    end
  endtask

  // Drives one strobe on a falling edge, returns one cycle later
  task automatic drive_issue(input logic [31:0] instr, a, b, input logic [3:0] tag);
    instr_valid_i = 1'b1;
    instr_i       = instr;
    operand_a_i   = a;
    operand_b_i   = b;
    tag_i         = tag;
    @(negedge clk);
    instr_valid_i = 1'b0;
  endtask

  task automatic run_op(input string name, input logic [31:0] instr, a, b, input bit fixed);
    logic [32:0] exp;
    logic [3:0]  tag;
    int          cycles;
    tag      = next_tag;
    next_tag = next_tag + 4'd1;
    exp      = reference_model(instr, a, b);
    drive_issue(instr, a, b, tag);
    cycles = 1;
    while (!result_valid_o) begin
      check_word(name, "busy_o while in flight", 32'h1, {31'h0, busy_o});
      @(negedge clk);
      cycles++;
    end
    if (fixed) check_word(name, "latency", 32'd2, cycles);
    check_word(name, "result", exp[31:0], result_o);
    check_word(name, "tag", {28'h0, tag}, {28'h0, result_tag_o});
    check_word(name, "illegal_o", {31'h0, exp[32]}, {31'h0, illegal_o});
    check_word(name, "busy_o with result", 32'h0, {31'h0, busy_o});
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic reset_idle_test();
    repeat (6) begin
      check_word("reset_idle", "result_valid_o", 32'h0, {31'h0, result_valid_o});
      check_word("reset_idle", "busy_o", 32'h0, {31'h0, busy_o});
      @(negedge clk);
    end
  endtask

  task automatic alu_tests();
    logic [31:0] a;
    for (int idx = 0; idx < 10; idx++) begin
      for (int k = 0; k < 4; k++) begin
        run_op($sformatf("alu_op_%0d", idx), alu_word(idx), random_bits(32), random_bits(32), 1);
      end
    end
    // Shift amounts 0 and 31 on a value with both end bits set
    a = random_bits(32) | 32'h8000_0001;
    for (int s = 0; s < 2; s++) begin
      run_op("sll_edge", alu_word(2), a, (s == 0) ? 32'h20 : 32'h1f, 1);
      run_op("srl_edge", alu_word(6), a, (s == 0) ? 32'h0 : 32'hffff_ffff, 1);
      run_op("sra_edge", alu_word(7), a, (s == 0) ? 32'h0 : 32'h1f, 1);
    end
    run_op("slt_edge", alu_word(3), 32'h8000_0000, 32'h7fff_ffff, 1);
    run_op("sltu_edge", alu_word(4), 32'h8000_0000, 32'h7fff_ffff, 1);
    run_op("slt_edge", alu_word(3), 32'hffff_ffff, 32'h0, 1);
    run_op("sltu_edge", alu_word(4), 32'hffff_ffff, 32'h0, 1);
    run_op("slt_equal", alu_word(3), a, a, 1);
  endtask

  task automatic muldiv_tests();
    logic [31:0] ma [4];
    logic [31:0] mb [4];
    logic [31:0] da [4];
    logic [31:0] db [4];
    ma = '{32'hffff_fff9, 32'h8000_0000, 32'h8000_0000, 32'hffff_ffff};
    mb = '{32'h0000_0003, 32'h8000_0000, 32'hffff_ffff, 32'hffff_ffff};
    da = '{random_bits(32), 32'h8000_0000, 32'hffff_ff9c, 32'h0000_0064};
    db = '{32'h0, 32'hffff_ffff, 32'h0000_0007, 32'hffff_fff9};
    for (int f = 0; f < 8; f++) begin
      for (int k = 0; k < 3; k++) begin
        run_op($sformatf("md_f3_%0d_rand", f), r_type(7'h01, f[2:0]), random_bits(32),
               (k == 0) ? random_bits(12) : random_bits(32), 0);
      end
      for (int k = 0; k < 4; k++) begin
        run_op($sformatf("md_f3_%0d_edge%0d", f, k), r_type(7'h01, f[2:0]),
               f[2] ? da[k] : ma[k], f[2] ? db[k] : mb[k], 0);
      end
    end
  endtask

  task automatic illegal_tests();
    run_op("illegal_alt_sll", r_type(7'h20, 3'd1), 32'h1234_5678, 32'h3, 1);
    run_op("illegal_alt_and", r_type(7'h20, 3'd7), random_bits(32), random_bits(32), 1);
    run_op("illegal_f7_02", r_type(7'h02, 3'd0), random_bits(32), random_bits(32), 1);
    run_op("illegal_f7_7f", r_type(7'h7f, 3'd5), random_bits(32), random_bits(32), 1);
    run_op("illegal_op_imm", with_opcode(r_type(7'h00, 3'd0), 7'b0010011), 32'h5, 32'h6, 1);
    run_op("illegal_lui", with_opcode(r_type(7'h00, 3'd0), 7'b0110111), 32'h5, 32'h6, 1);
    run_op("illegal_zero", 32'h0, random_bits(32), random_bits(32), 1);
  endtask

  // Divide in flight, a strobe while busy must be dropped
  task automatic busy_drop_test();
    logic [31:0] a, b;
    logic [32:0] exp;
    a   = random_bits(32);
    b   = random_bits(16);
    exp = reference_model(r_type(7'h01, 3'd4), a, b);
    drive_issue(r_type(7'h01, 3'd4), a, b, 4'ha);
    repeat (8) begin
      check_word("busy_drop", "busy_o during divide", 32'h1, {31'h0, busy_o});
      @(negedge clk);
    end
    drive_issue(alu_word(0), 32'h1, 32'h2, 4'h5);
    while (!result_valid_o) begin
      check_word("busy_drop", "busy_o during divide", 32'h1, {31'h0, busy_o});
      @(negedge clk);
    end
    check_word("busy_drop", "result", exp[31:0], result_o);
    check_word("busy_drop", "tag", 32'ha, {28'h0, result_tag_o});
    repeat (40) begin
      @(negedge clk);
      n_checks++;
      assert (!result_valid_o) else begin
        $display("Dropped strobe in busy_drop still produced a result");
        n_errors++;
      end
    end
    run_op("busy_follow", alu_word(0), random_bits(32), random_bits(32), 1);
  endtask

  initial begin
    rst_n_i       = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    operand_a_i   = '0;
    operand_b_i   = '0;
    tag_i         = '0;
    next_tag      = 4'h1;
    repeat (4) @(negedge clk);
    rst_n_i = 1'b1;
    reset_idle_test();
    alu_tests();
    muldiv_tests();
    illegal_tests();
    busy_drop_test();
    @(negedge clk);
    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
